// ==== mem2Consts.svh ====
`ifndef MEM2_CONSTS_SVH
`define MEM2_CONSTS_SVH

// data path, addresses and instructions share one width
`define MEM2_DATA_W 32

// general register index
`define MEM2_REG_ADDR_W 5

// exception code, zero means no exception
`define MEM2_EXC_W 5

// return address of a link instruction is pc + 8, past the delay slot
`define MEM2_LINK_OFFSET 8

// lane widths inside a data word
`define MEM2_BYTE_W 8
`define MEM2_HALF_W 16

`endif

// ==== cpuTypesPkg.sv ====
`default_nettype none

`include "mem2Consts.svh"

package cpuTypesPkg;

    // data, address or instruction word
    typedef logic [`MEM2_DATA_W-1:0] word;

    // general register index
    typedef logic [`MEM2_REG_ADDR_W-1:0] regAddr;

    // exception code, all zeros is no exception
    typedef logic [`MEM2_EXC_W-1:0] excCode;

    // source of the register writeback value
    // zero is the alu result, which is also what a cleared stage selects
    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbLoad = 2'd1,
        wbLink = 2'd2,
        // mfhi/mflo, value already sits in aluOut
        wbHiLo = 2'd3
    } wbSel;

    // kind of load in flight
    // none must stay zero so that reset and flush leave no load behind
    typedef enum logic [2:0] {
        ldNone  = 3'd0,
        ldByte  = 3'd1,
        ldByteU = 3'd2,
        ldHalf  = 3'd3,
        ldHalfU = 3'd4,
        ldWord  = 3'd5
    } loadKind;

endpackage

`default_nettype wire

// ==== pipeBundlePkg.sv ====
`default_nettype none

package pipeBundlePkg;

    // write enables after exception resolution
    typedef struct packed {
        logic gprWr;
        logic hiWr;
        logic loWr;
    } regsWr;

    // everything the mem stage hands over
    typedef struct packed {
        cpuTypesPkg::word     aluOut;
        cpuTypesPkg::word     pc;
        cpuTypesPkg::word     instr;
        cpuTypesPkg::wbSel    wbSel;
        cpuTypesPkg::regAddr  dst;
        // store data, carried along for the next stages
        cpuTypesPkg::word     outB;
        regsWr                regsWr;
        cpuTypesPkg::excCode  excType;
        logic                 isBranch;
        logic                 isJumpCall;
        logic                 isInDelaySlot;
        cpuTypesPkg::loadKind loadKind;
    } memBundle;

    // held in the mem2 register, same layout
    typedef memBundle mem2Bundle;

    // register file write request
    typedef struct packed {
        regsWr               regsWr;
        cpuTypesPkg::regAddr dst;
        cpuTypesPkg::word    data;
    } wbRequest;

    // commit record for the retiring instruction
    typedef struct packed {
        cpuTypesPkg::word    pc;
        cpuTypesPkg::word    instr;
        cpuTypesPkg::excCode excType;
        logic                isBranch;
        logic                isJumpCall;
        logic                isInDelaySlot;
    } commitInfo;

endpackage

`default_nettype wire

// ==== mem2Reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem2Reg (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     flush,
    input  logic                     wr,
    input  pipeBundlePkg::memBundle  memIn,
    output pipeBundlePkg::mem2Bundle stage
);

    // one instruction held between mem and writeback
    // flush wins over wr, a killed slot must never load
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            // all zero leaves no write, no exception and no load
            stage <= '0;
        end else if (wr) begin
            stage <= memIn;
        end
        // wr low holds the current instruction while the pipe stalls
    end

endmodule

`default_nettype wire

// ==== loadAligner.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem2Consts.svh"

module loadAligner (
    input  cpuTypesPkg::loadKind loadKind,
    input  logic [1:0]           byteOffset,
    input  cpuTypesPkg::word     rdata,
    output cpuTypesPkg::word     loadData
);

    logic [`MEM2_BYTE_W-1:0] byteLane;
    logic [`MEM2_HALF_W-1:0] halfLane;

    // little endian, lane 0 in the low bits
    always_comb begin
        case (byteOffset)
            2'd0:    byteLane = rdata[7:0];
            2'd1:    byteLane = rdata[15:8];
            2'd2:    byteLane = rdata[23:16];
            default: byteLane = rdata[31:24];
        endcase
    end

    // halfword loads are aligned, only bit 1 matters
    always_comb begin
        if (byteOffset[1]) begin
            halfLane = rdata[31:16];
        end else begin
            halfLane = rdata[15:0];
        end
    end

    // extend to a full word
    always_comb begin
        case (loadKind)
            cpuTypesPkg::ldByte: begin
                loadData = {{(`MEM2_DATA_W-`MEM2_BYTE_W){byteLane[`MEM2_BYTE_W-1]}},
                            byteLane};
            end
            cpuTypesPkg::ldByteU: begin
                loadData = {{(`MEM2_DATA_W-`MEM2_BYTE_W){1'b0}}, byteLane};
            end
            cpuTypesPkg::ldHalf: begin
                loadData = {{(`MEM2_DATA_W-`MEM2_HALF_W){halfLane[`MEM2_HALF_W-1]}},
                            halfLane};
            end
            cpuTypesPkg::ldHalfU: begin
                loadData = {{(`MEM2_DATA_W-`MEM2_HALF_W){1'b0}}, halfLane};
            end
            // word and none take the cache word as it comes
            default: begin
                loadData = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== writebackSelect.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem2Consts.svh"

module writebackSelect (
    input  pipeBundlePkg::mem2Bundle stage,
    input  cpuTypesPkg::word         loadData,
    output pipeBundlePkg::wbRequest  wbOut,
    output pipeBundlePkg::commitInfo commitOut
);

    cpuTypesPkg::word wbData;
    cpuTypesPkg::word linkAddr;

    // return address skips the delay slot
    assign linkAddr = stage.pc + cpuTypesPkg::word'(`MEM2_LINK_OFFSET);

    always_comb begin
        case (stage.wbSel)
            cpuTypesPkg::wbLoad: wbData = loadData;
            cpuTypesPkg::wbLink: wbData = linkAddr;
            // hi/lo moves were already routed through the alu
            cpuTypesPkg::wbHiLo: wbData = stage.aluOut;
            default:             wbData = stage.aluOut;
        endcase
    end

    // enables are final from mem, just forwarded
    always_comb begin
        wbOut.regsWr = stage.regsWr;
        wbOut.dst    = stage.dst;
        wbOut.data   = wbData;
    end

    always_comb begin
        commitOut.pc            = stage.pc;
        commitOut.instr         = stage.instr;
        commitOut.excType       = stage.excType;
        commitOut.isBranch      = stage.isBranch;
        commitOut.isJumpCall    = stage.isJumpCall;
        commitOut.isInDelaySlot = stage.isInDelaySlot;
    end

endmodule

`default_nettype wire

// ==== mem2Stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem2Stage (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     flush,
    input  logic                     wr,
    input  pipeBundlePkg::memBundle  memIn,
    // read word of the load issued in mem, arrives this cycle
    input  cpuTypesPkg::word         dcacheRdata,
    output pipeBundlePkg::wbRequest  wbOut,
    output pipeBundlePkg::commitInfo commitOut
);

    pipeBundlePkg::mem2Bundle stage;
    cpuTypesPkg::word         loadData;

    mem2Reg i_reg (
        .clk   (clk),
        .rstN  (rstN),
        .flush (flush),
        .wr    (wr),
        .memIn (memIn),
        .stage (stage)
    );

    // low address bits pick the lane
    loadAligner i_aligner (
        .loadKind   (stage.loadKind),
        .byteOffset (stage.aluOut[1:0]),
        .rdata      (dcacheRdata),
        .loadData   (loadData)
    );

    writebackSelect i_wbSel (
        .stage     (stage),
        .loadData  (loadData),
        .wbOut     (wbOut),
        .commitOut (commitOut)
    );

endmodule

`default_nettype wire

// ==== mem2Assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem2Assertions (
    input logic                     clk,
    input logic                     rstN,
    input logic                     flush,
    input logic                     wr,
    input pipeBundlePkg::memBundle  memIn,
    input pipeBundlePkg::mem2Bundle stage
);

    // reset leaves an empty slot behind
    property clearOnReset;
        @(posedge clk) !rstN |=> (stage == '0);
    endproperty

    // flush kills the slot even when wr is high
    property clearOnFlush;
        @(posedge clk) (rstN && flush) |=> (stage == '0);
    endproperty

    // stalled pipe keeps its instruction
    property holdOnStall;
        @(posedge clk) (rstN && !flush && !wr) |=> $stable(stage);
    endproperty

    property loadOnWrite;
        @(posedge clk) (rstN && !flush && wr) |=> (stage == $past(memIn));
    endproperty

    assert property (clearOnReset) else $error("stage not cleared after reset");
    assert property (clearOnFlush) else $error("stage not cleared after flush");
    assert property (holdOnStall) else $error("stage changed while wr was low");
    assert property (loadOnWrite) else $error("stage did not take memIn on a write");

endmodule

bind mem2Reg mem2Assertions i_assert (
    .clk   (clk),
    .rstN  (rstN),
    .flush (flush),
    .wr    (wr),
    .memIn (memIn),
    .stage (stage)
);

`default_nettype wire

// ==== mem2Checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem2Checker #(
    parameter int NAME_W = 192
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     flush,
    input  logic                     wr,
    input  pipeBundlePkg::memBundle  memIn,
    input  pipeBundlePkg::wbRequest  wbOut,
    input  pipeBundlePkg::commitInfo commitOut,
    // one check per test, raised by the stimulus side
    input  logic                     checkReq,
    input  int                       testIdx,
    input  logic [NAME_W-1:0]        testName,
    input  cpuTypesPkg::word         expData,
    output int                       doneCount,
    output int                       errorCount
);

    // what the stage register should hold right now
    pipeBundlePkg::mem2Bundle model;
    int                       testErrors;

    initial begin
        model      = '0;
        doneCount  = 0;
        errorCount = 0;
        testErrors = 0;
    end

    task automatic checkValue(input string sigName, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %0s expected %h, got %h", $time, sigName, exp, act);
            testErrors++;
            errorCount++;
        end
    endtask

    always @(posedge clk) begin
        // outputs still show the bundle from before this edge
        if (checkReq) begin
            testErrors = 0;
            checkValue("wbOut.regsWr", {29'h0, model.regsWr}, {29'h0, wbOut.regsWr});
            checkValue("wbOut.dst", {27'h0, model.dst}, {27'h0, wbOut.dst});
            checkValue("wbOut.data", expData, wbOut.data);
            checkValue("commitOut.pc", model.pc, commitOut.pc);
            checkValue("commitOut.instr", model.instr, commitOut.instr);
            checkValue("commitOut.excType", {27'h0, model.excType},
                       {27'h0, commitOut.excType});
            checkValue("commitOut.isBranch", {31'h0, model.isBranch},
                       {31'h0, commitOut.isBranch});
            checkValue("commitOut.isJumpCall", {31'h0, model.isJumpCall},
                       {31'h0, commitOut.isJumpCall});
            checkValue("commitOut.isInDelaySlot", {31'h0, model.isInDelaySlot},
                       {31'h0, commitOut.isInDelaySlot});
            if (testErrors == 0) begin
                $display("test %0d %0s: ok", testIdx, testName);
            end else begin
                $display("test %0d %0s: %0d mismatches", testIdx, testName, testErrors);
            end
            doneCount++;
        end
        // flush beats wr
        if (!rstN || flush) begin
            model = '0;
        end else if (wr) begin
            model = memIn;
        end
    end

endmodule

`default_nettype wire

// ==== tbMem2Stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem2Consts.svh"

module tbMem2Stage;

    localparam int NUM_TESTS     = 31;
    localparam int CHECK_TIMEOUT = 20;
    localparam int NAME_W        = 8 * 24;

    logic                     clk;
    logic                     rstN;
    logic                     flush;
    logic                     wr;
    pipeBundlePkg::memBundle  memIn;
    cpuTypesPkg::word         dcacheRdata;
    pipeBundlePkg::wbRequest  wbOut;
    pipeBundlePkg::commitInfo commitOut;

    logic                     checkReq;
    int                       testIdx;
    logic [NAME_W-1:0]        testName;
    cpuTypesPkg::word         expData;
    int                       doneCount;
    int                       errorCount;

    // stimulus table, one row per test
    logic [NAME_W-1:0]        nameTab  [NUM_TESTS];
    pipeBundlePkg::memBundle  memTab   [NUM_TESTS];
    cpuTypesPkg::word         rdataTab [NUM_TESTS];
    logic                     wrTab    [NUM_TESTS];
    logic                     flushTab [NUM_TESTS];
    cpuTypesPkg::word         expTab   [NUM_TESTS];

    integer                   seed;
    int                       numRows;
    logic                     timedOut;

    mem2Stage i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .wr          (wr),
        .memIn       (memIn),
        .dcacheRdata (dcacheRdata),
        .wbOut       (wbOut),
        .commitOut   (commitOut)
    );

    mem2Checker #(.NAME_W(NAME_W)) i_checker (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .wr         (wr),
        .memIn      (memIn),
        .wbOut      (wbOut),
        .commitOut  (commitOut),
        .checkReq   (checkReq),
        .testIdx    (testIdx),
        .testName   (testName),
        .expData    (expData),
        .doneCount  (doneCount),
        .errorCount (errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // lane pick and extension, little endian
    function automatic cpuTypesPkg::word expectLoad(input cpuTypesPkg::loadKind kind,
                                                    input logic [1:0] offset,
                                                    input cpuTypesPkg::word rdata);
        cpuTypesPkg::word byteShift;
        cpuTypesPkg::word halfShift;
        byteShift = rdata >> {offset, 3'b000};
        halfShift = rdata >> {offset[1], 4'b0000};
        case (kind)
            cpuTypesPkg::ldByte:  return {{24{byteShift[7]}}, byteShift[7:0]};
            cpuTypesPkg::ldByteU: return {24'h0, byteShift[7:0]};
            cpuTypesPkg::ldHalf:  return {{16{halfShift[15]}}, halfShift[15:0]};
            cpuTypesPkg::ldHalfU: return {16'h0, halfShift[15:0]};
            default:              return rdata;
        endcase
    endfunction

    function automatic logic [NAME_W-1:0] loadName(input int kind);
        case (kind)
            1:       return "load signed byte";
            2:       return "load unsigned byte";
            3:       return "load signed half";
            4:       return "load unsigned half";
            5:       return "load word";
            default: return "load kind none";
        endcase
    endfunction

    task automatic randomBundle(output pipeBundlePkg::memBundle b);
        logic [31:0] flags;
        b          = '0;
        b.aluOut   = $random(seed);
        b.pc       = $random(seed) & 32'hFFFF_FFFC;
        b.instr    = $random(seed);
        b.outB     = $random(seed);
        flags      = $random(seed);
        b.dst      = flags[4:0];
        b.isBranch = flags[8];
        b.isJumpCall    = flags[9];
        b.isInDelaySlot = flags[10];
    endtask

    task automatic addRow(input logic [NAME_W-1:0] name, input pipeBundlePkg::memBundle b,
                          input cpuTypesPkg::word rdata, input logic w, input logic f,
                          input cpuTypesPkg::word exp);
        nameTab[numRows]  = name;
        memTab[numRows]   = b;
        rdataTab[numRows] = rdata;
        wrTab[numRows]    = w;
        flushTab[numRows] = f;
        expTab[numRows]   = exp;
        numRows++;
    endtask

    task automatic buildTable();
        pipeBundlePkg::memBundle b;
        cpuTypesPkg::word        rdata;
        cpuTypesPkg::word        linkData;
        numRows = 0;
        // wr low, so the busy bundle must not get in
        randomBundle(b);
        b.regsWr  = 3'b111;
        b.excType = 5'd9;
        addRow("reset state", b, $random(seed), 1'b0, 1'b0, 32'h0);
        randomBundle(b);
        b.wbSel  = cpuTypesPkg::wbAlu;
        b.regsWr = 3'b100;
        addRow("alu writeback", b, $random(seed), 1'b1, 1'b0, b.aluOut);
        randomBundle(b);
        b.wbSel  = cpuTypesPkg::wbHiLo;
        b.regsWr = 3'b011;
        addRow("hi lo move", b, $random(seed), 1'b1, 1'b0, b.aluOut);
        for (int k = 0; k < 6; k++) begin
            for (int off = 0; off < 4; off++) begin
                randomBundle(b);
                b.wbSel       = cpuTypesPkg::wbLoad;
                b.loadKind    = cpuTypesPkg::loadKind'(k);
                b.aluOut[1:0] = 2'(off);
                b.regsWr      = 3'b100;
                rdata         = $random(seed);
                addRow(loadName(k), b, rdata, 1'b1, 1'b0,
                       expectLoad(b.loadKind, 2'(off), rdata));
            end
        end
        randomBundle(b);
        b.regsWr        = 3'b000;
        b.excType       = 5'd12;
        b.isInDelaySlot = 1'b1;
        addRow("exception commit", b, $random(seed), 1'b1, 1'b0, b.aluOut);
        randomBundle(b);
        b.wbSel      = cpuTypesPkg::wbLink;
        b.regsWr     = 3'b100;
        b.dst        = 5'd31;
        b.isJumpCall = 1'b1;
        linkData     = b.pc + `MEM2_LINK_OFFSET;
        addRow("link writeback", b, $random(seed), 1'b1, 1'b0, linkData);
        // link result has to survive a changed memIn
        randomBundle(b);
        b.regsWr = 3'b111;
        addRow("stall holds", b, $random(seed), 1'b0, 1'b0, linkData);
        randomBundle(b);
        b.wbSel    = cpuTypesPkg::wbLoad;
        b.loadKind = cpuTypesPkg::ldWord;
        b.regsWr   = 3'b111;
        b.excType  = 5'd4;
        addRow("flush beats write", b, $random(seed), 1'b1, 1'b1, 32'h0);
    endtask

    task automatic waitForCheck(input int target);
        int cycles;
        cycles = 0;
        while (doneCount < target && cycles < CHECK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (doneCount < target) begin
            $display("test %0d never completed, no check within %0d cycles",
                     target - 1, CHECK_TIMEOUT);
            timedOut = 1'b1;
        end
    endtask

    // called on a falling edge, returns on one
    task automatic applyRow(input int i);
        memIn       = memTab[i];
        wr          = wrTab[i];
        flush       = flushTab[i];
        // the row's cache word only arrives in the next cycle
        dcacheRdata = ~rdataTab[i];
        checkReq    = 1'b0;
        @(negedge clk);
        wr          = 1'b0;
        flush       = 1'b0;
        dcacheRdata = rdataTab[i];
        testIdx     = i;
        testName    = nameTab[i];
        expData     = expTab[i];
        checkReq    = 1'b1;
        waitForCheck(i + 1);
        checkReq    = 1'b0;
    endtask

    initial begin
        seed        = 32'h1191;
        timedOut    = 1'b0;
        rstN        = 1'b0;
        flush       = 1'b0;
        wr          = 1'b0;
        memIn       = '0;
        dcacheRdata = '0;
        checkReq    = 1'b0;
        testIdx     = 0;
        testName    = '0;
        expData     = '0;
        buildTable();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < numRows && !timedOut; i++) begin
            applyRow(i);
        end
        $display("tests %0d, checked %0d, errors %0d", numRows, doneCount, errorCount);
        if (!timedOut && errorCount == 0 && doneCount == numRows) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem2Stage.f ====
+incdir+.
cpuTypesPkg.sv
pipeBundlePkg.sv
mem2Reg.sv
loadAligner.sv
writebackSelect.sv
mem2Stage.sv
mem2Assertions.sv
mem2Checker.sv
tbMem2Stage.sv
